/* source/lsu_pkg.sv */
package lsu_pkg;

    localparam int DATA_W          = 64;
    localparam int ADDR_W          = 32;
    localparam int RAM_WORDS       = 256;
    localparam int RAM_WAIT_CYCLES = 2;

    // Derived widths for the memory model
    localparam int RAM_IDX_W  = $clog2(RAM_WORDS);
    localparam int WAIT_CNT_W = $clog2(RAM_WAIT_CYCLES + 1);

    // Low two bits give the width
    // Bit 2 marks the unsigned forms and LD
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LD   = 3'd4,
        LOAD_LBU  = 3'd5,
        LOAD_LHU  = 3'd6,
        LOAD_LWU  = 3'd7
    } load_op_e;

    // Bit 2 enables the store
    typedef enum logic [2:0] {
        STORE_NONE = 3'd0,
        STORE_SB   = 3'd4,
        STORE_SH   = 3'd5,
        STORE_SW   = 3'd6,
        STORE_SD   = 3'd7
    } store_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } size_e;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_e;

    typedef struct packed {
        size_e size;
        logic  load_signed;
        logic  is_load;
        logic  is_store;
    } lsu_op_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        size_e             size;
        req_e              req;
    } bus_req_t;

    // Bit mask covering the low bytes of one access
    function automatic logic [DATA_W-1:0] size_bit_mask(input size_e size);
        logic [DATA_W-1:0] mask;
        case (size)
            SIZE_B:  mask = 64'h0000_0000_0000_00ff;
            SIZE_H:  mask = 64'h0000_0000_0000_ffff;
            SIZE_W:  mask = 64'h0000_0000_ffff_ffff;
            default: mask = '1;
        endcase
        return mask;
    endfunction

endpackage

/* source/lsu_op_decode.sv */
module lsu_op_decode (
    input  lsu_pkg::load_op_e  load_op_i,
    input  lsu_pkg::store_op_e store_op_i,
    output lsu_pkg::lsu_op_t   op_o
);
    import lsu_pkg::*;

    size_e load_size;
    size_e store_size;
    logic  store_en;

    assign store_en = store_op_i[2];

    // Load width from the low two bits where zero means LD
    always_comb begin
        case (load_op_i[1:0])
            2'b01:   load_size = SIZE_B;
            2'b10:   load_size = SIZE_H;
            2'b11:   load_size = SIZE_W;
            default: load_size = SIZE_D;
        endcase
    end

    always_comb begin
        case (store_op_i)
            STORE_SB: store_size = SIZE_B;
            STORE_SH: store_size = SIZE_H;
            STORE_SW: store_size = SIZE_W;
            default:  store_size = SIZE_D;
        endcase
    end

    always_comb begin
        op_o.is_store    = store_en;
        op_o.is_load     = (load_op_i != LOAD_NONE);
        op_o.load_signed = ~load_op_i[2] & (|load_op_i[1:0]);
        // Store code takes the size whenever its enable is set
        if (store_en) begin
            op_o.size = store_size;
        end else begin
            op_o.size = load_size;
        end
    end

endmodule

/* source/lsu_bus_ctrl.sv */
module lsu_bus_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         intp_en_i,
    input  logic                         inst_valid_i,
    input  logic                         mem_read_i,
    input  logic                         mem_write_i,
    input  logic [lsu_pkg::ADDR_W-1:0]   addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]   wdata_i,
    input  lsu_pkg::lsu_op_t             op_i,
    input  logic                         bus_ready_i,
    input  logic [lsu_pkg::DATA_W-1:0]   bus_rdata_i,
    output logic                         bus_valid_o,
    output lsu_pkg::bus_req_t            bus_req_o,
    output logic [lsu_pkg::DATA_W-1:0]   rdata_o,
    output logic                         access_ok_o
);
    import lsu_pkg::*;

    logic              finished;
    logic              handshake;
    logic [5:0]        lane_shift;
    logic [DATA_W-1:0] read_data_r;

    // No new request once this instruction has completed
    assign bus_valid_o = (mem_read_i | mem_write_i) & ~finished & ~intp_en_i;
    assign handshake   = bus_valid_o & bus_ready_i;

    assign lane_shift = {addr_i[2:0], 3'b000};

    always_comb begin
        bus_req_o.addr  = addr_i;
        bus_req_o.wdata = wdata_i << lane_shift;
        bus_req_o.size  = op_i.size;
        if (mem_write_i && op_i.is_store) begin
            bus_req_o.req = REQ_WRITE;
        end else begin
            bus_req_o.req = REQ_READ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || inst_valid_i) begin
            finished <= 1'b0;
        end else if (handshake) begin
            finished <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_data_r <= '0;
        end else if (handshake && mem_read_i) begin
            read_data_r <= bus_rdata_i;
        end
    end

    // Interrupt reports completion without touching memory
    assign access_ok_o = finished | intp_en_i;
    assign rdata_o     = read_data_r;

endmodule

/* source/lsu_load_extend.sv */
module lsu_load_extend (
    input  logic [lsu_pkg::DATA_W-1:0] rdata_i,
    input  lsu_pkg::lsu_op_t           op_i,
    output logic [lsu_pkg::DATA_W-1:0] rdata_o
);
    import lsu_pkg::*;

    logic [DATA_W-1:0] width_mask;
    logic              top_bit;
    logic              fill;

    assign width_mask = size_bit_mask(op_i.size);

    // Top bit of the loaded width
    always_comb begin
        case (op_i.size)
            SIZE_B:  top_bit = rdata_i[7];
            SIZE_H:  top_bit = rdata_i[15];
            SIZE_W:  top_bit = rdata_i[31];
            default: top_bit = rdata_i[63];
        endcase
    end

    assign fill = op_i.is_load & op_i.load_signed & top_bit;

    // Memory already returns zero above the width, so unsigned passes through
    always_comb begin
        if (fill) begin
            rdata_o = rdata_i | ~width_mask;
        end else begin
            rdata_o = rdata_i;
        end
    end

endmodule

/* source/data_ram.sv */
module data_ram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid_i,
    input  lsu_pkg::bus_req_t          req_i,
    output logic                       ready_o,
    output logic [lsu_pkg::DATA_W-1:0] rdata_o
);
    import lsu_pkg::*;

    localparam logic [WAIT_CNT_W-1:0] LAST_WAIT = WAIT_CNT_W'(RAM_WAIT_CYCLES - 1);

    logic [DATA_W-1:0]     mem [RAM_WORDS];
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic [RAM_IDX_W-1:0]  word_idx;
    logic [5:0]            lane_shift;
    logic [DATA_W-1:0]     write_mask;
    logic [DATA_W-1:0]     merged;
    logic [DATA_W-1:0]     read_aligned;
    logic                  ready_next;

    assign word_idx   = req_i.addr[3 +: RAM_IDX_W];
    assign lane_shift = {req_i.addr[2:0], 3'b000};

    // Write data arrives on its lanes already
    assign write_mask = size_bit_mask(req_i.size) << lane_shift;
    assign merged     = (mem[word_idx] & ~write_mask) | (req_i.wdata & write_mask);

    assign read_aligned = (mem[word_idx] >> lane_shift) & size_bit_mask(req_i.size);

    // Ready follows a full wait with valid held
    assign ready_next = valid_i & ~ready_o & (wait_cnt == LAST_WAIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_o  <= 1'b0;
            wait_cnt <= '0;
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ready_o <= ready_next;
            if (!valid_i || ready_o) begin
                wait_cnt <= '0;
            end else if (wait_cnt != LAST_WAIT) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (valid_i && ready_o && req_i.req == REQ_WRITE) begin
                mem[word_idx] <= merged;
            end
        end
    end

    // Read data is presented together with ready
    always_ff @(posedge clk) begin
        if (ready_next) begin
            rdata_o <= read_aligned;
        end
    end

endmodule

/* source/mem_stage_top.sv */
module mem_stage_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       intp_en_i,
    input  logic                       inst_valid_i,
    input  lsu_pkg::load_op_e          load_op_i,
    input  lsu_pkg::store_op_e         store_op_i,
    input  logic                       mem_read_i,
    input  logic                       mem_write_i,
    input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
    input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
    output logic                       access_ok_o,
    output logic [lsu_pkg::DATA_W-1:0] rdata_o
);
    import lsu_pkg::*;

    lsu_op_t           op;
    bus_req_t          bus_req;
    logic              bus_valid;
    logic              bus_ready;
    logic [DATA_W-1:0] bus_rdata;
    logic [DATA_W-1:0] read_data_raw;

    lsu_op_decode u_decode (
        .load_op_i  (load_op_i),
        .store_op_i (store_op_i),
        .op_o       (op)
    );

    lsu_bus_ctrl u_bus_ctrl (
        .clk          (clk),
        .rst          (rst),
        .intp_en_i    (intp_en_i),
        .inst_valid_i (inst_valid_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .op_i         (op),
        .bus_ready_i  (bus_ready),
        .bus_rdata_i  (bus_rdata),
        .bus_valid_o  (bus_valid),
        .bus_req_o    (bus_req),
        .rdata_o      (read_data_raw),
        .access_ok_o  (access_ok_o)
    );

    lsu_load_extend u_extend (
        .rdata_i (read_data_raw),
        .op_i    (op),
        .rdata_o (rdata_o)
    );

    data_ram u_ram (
        .clk     (clk),
        .rst     (rst),
        .valid_i (bus_valid),
        .req_i   (bus_req),
        .ready_o (bus_ready),
        .rdata_o (bus_rdata)
    );

endmodule

/* tb/tb_mem_stage.sv */
module tb_mem_stage;
    import lsu_pkg::*;

    localparam int NUM_TESTS       = 27;
    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (RAM_WAIT_CYCLES + 6) + 10;

    typedef struct packed {
        logic        is_store;
        logic [2:0]  op;
        logic [31:0] addr;
        logic        intp;
        logic        hold;
        logic        use_rand;
        logic [63:0] data;
        logic [3:0]  exp_edges;
    } entry_t;

    logic              clk;
    logic              rst;
    logic              intp_en_i;
    logic              inst_valid_i;
    load_op_e          load_op_i;
    store_op_e         store_op_i;
    logic              mem_read_i;
    logic              mem_write_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    logic              access_ok_o;
    logic [DATA_W-1:0] rdata_o;

    entry_t      stim [NUM_TESTS];
    logic [7:0]  ref_mem [RAM_WORDS*8];
    int          errors;

    mem_stage_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .intp_en_i    (intp_en_i),
        .inst_valid_i (inst_valid_i),
        .load_op_i    (load_op_i),
        .store_op_i   (store_op_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .access_ok_o  (access_ok_o),
        .rdata_o      (rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    function automatic entry_t make_entry(input logic is_store, input logic [2:0] op,
                                          input logic [31:0] addr, input logic intp,
                                          input logic hold, input logic use_rand,
                                          input logic [63:0] data);
        entry_t e;
        e.is_store  = is_store;
        e.op        = op;
        e.addr      = addr;
        e.intp      = intp;
        e.hold      = hold;
        e.use_rand  = use_rand;
        e.data      = data;
        // Wait cycles plus the handshake edge unless an interrupt completes it at once
        e.exp_edges = intp ? 4'd0 : 4'(RAM_WAIT_CYCLES + 1);
        return e;
    endfunction

    task automatic build_table();
        stim[0]  = make_entry(1, STORE_SD, 32'h00, 0, 0, 1, 64'h0);
        stim[1]  = make_entry(1, STORE_SB, 32'h03, 0, 0, 1, 64'h0);
        stim[2]  = make_entry(1, STORE_SH, 32'h06, 0, 0, 1, 64'h0);
        stim[3]  = make_entry(1, STORE_SW, 32'h0c, 0, 0, 1, 64'h0);
        stim[4]  = make_entry(1, STORE_SB, 32'h08, 0, 0, 1, 64'h0);
        stim[5]  = make_entry(1, STORE_SH, 32'h0a, 0, 0, 1, 64'h0);
        stim[6]  = make_entry(0, LOAD_LD,  32'h00, 0, 0, 0, 64'h0);
        stim[7]  = make_entry(0, LOAD_LD,  32'h08, 0, 0, 0, 64'h0);
        stim[8]  = make_entry(1, STORE_SW, 32'h10, 0, 0, 1, 64'h0);
        stim[9]  = make_entry(1, STORE_SD, 32'h18, 0, 0, 1, 64'h0);
        stim[10] = make_entry(1, STORE_SH, 32'h1c, 0, 0, 1, 64'h0);
        stim[11] = make_entry(0, LOAD_LD,  32'h10, 0, 0, 0, 64'h0);
        stim[12] = make_entry(0, LOAD_LD,  32'h18, 0, 0, 0, 64'h0);
        // Word with the top bit set in most widths
        stim[13] = make_entry(1, STORE_SD, 32'h40, 0, 0, 0, 64'h89ab_cdef_f1e2_d3c4);
        stim[14] = make_entry(1, STORE_SB, 32'h43, 0, 0, 0, 64'h7f);
        stim[15] = make_entry(0, LOAD_LB,  32'h40, 0, 0, 0, 64'h0);
        stim[16] = make_entry(0, LOAD_LBU, 32'h40, 0, 0, 0, 64'h0);
        stim[17] = make_entry(0, LOAD_LB,  32'h43, 0, 0, 0, 64'h0);
        stim[18] = make_entry(0, LOAD_LH,  32'h46, 0, 0, 0, 64'h0);
        stim[19] = make_entry(0, LOAD_LHU, 32'h40, 0, 0, 0, 64'h0);
        stim[20] = make_entry(0, LOAD_LW,  32'h44, 0, 0, 0, 64'h0);
        stim[21] = make_entry(0, LOAD_LWU, 32'h44, 0, 0, 0, 64'h0);
        stim[22] = make_entry(0, LOAD_LD,  32'h40, 0, 0, 0, 64'h0);
        stim[23] = make_entry(1, STORE_SD, 32'h40, 1, 0, 1, 64'h0);
        stim[24] = make_entry(0, LOAD_LD,  32'h40, 0, 0, 0, 64'h0);
        stim[25] = make_entry(1, STORE_SD, 32'h80, 0, 1, 1, 64'h0);
        stim[26] = make_entry(0, LOAD_LD,  32'h80, 0, 0, 0, 64'h0);
    endtask

    function automatic logic [63:0] random_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic int load_bytes(input logic [2:0] op);
        case (op)
            3'd1, 3'd5: return 1;
            3'd2, 3'd6: return 2;
            3'd3, 3'd7: return 4;
            default:    return 8;
        endcase
    endfunction

    function automatic logic [63:0] expected_load(input logic [2:0] op, input logic [31:0] addr);
        logic [63:0] val;
        int          n;
        logic        sgn;
        n   = load_bytes(op);
        val = '0;
        sgn = (op == LOAD_LB) || (op == LOAD_LH) || (op == LOAD_LW);
        for (int k = 0; k < n; k++) begin
            val[8*k +: 8] = ref_mem[int'(addr) + k];
        end
        if (sgn && val[8*n-1]) begin
            for (int b = 8 * n; b < 64; b++) begin
                val[b] = 1'b1;
            end
        end
        return val;
    endfunction

    // Store sizes are 1, 2, 4 and 8 bytes for the low code bits
    task automatic apply_store(input logic [2:0] op, input logic [31:0] addr,
                               input logic [63:0] data);
        int n;
        n = 1 << op[1:0];
        for (int k = 0; k < n; k++) begin
            ref_mem[int'(addr) + k] = data[8*k +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_entry(input int idx);
        entry_t      e;
        logic [63:0] data;
        int          edges;
        int          errs_before;
        e           = stim[idx];
        errs_before = errors;
        data        = e.use_rand ? random_word() : e.data;
        intp_en_i   = e.intp;
        addr_i      = e.addr;
        wdata_i     = data;
        if (e.is_store) begin
            store_op_i  = store_op_e'(e.op);
            load_op_i   = LOAD_NONE;
            mem_write_i = 1'b1;
            mem_read_i  = 1'b0;
        end else begin
            store_op_i  = STORE_NONE;
            load_op_i   = load_op_e'(e.op);
            mem_write_i = 1'b0;
            mem_read_i  = 1'b1;
        end
        // Count rising edges between the drive and the first sample with access_ok_o high
        edges = 0;
        @(negedge clk);
        while (!access_ok_o && edges < 20) begin
            @(negedge clk);
            edges++;
        end
        if (!access_ok_o) begin
            $display("Test %0d: access_ok_o never rose", idx);
            errors++;
        end else begin
            check_value("access_ok_edges", 64'(edges), 64'(e.exp_edges));
            if (!e.is_store) begin
                check_value("rdata_o", rdata_o, expected_load(e.op, e.addr));
            end else if (!e.intp) begin
                apply_store(e.op, e.addr, data);
            end
        end
        if (e.hold) begin
            // New data while finished must not reach memory
            for (int c = 0; c < 3; c++) begin
                @(posedge clk);
                #1 wdata_i = random_word();
                @(negedge clk);
                check_value("access_ok_o", 64'(access_ok_o), 64'h1);
            end
        end
        @(posedge clk);
        #1;
        inst_valid_i = 1'b1;
        intp_en_i    = 1'b0;
        mem_read_i   = 1'b0;
        mem_write_i  = 1'b0;
        load_op_i    = LOAD_NONE;
        store_op_i   = STORE_NONE;
        @(posedge clk);
        #1 inst_valid_i = 1'b0;
        $display("Test %0d %s addr 0x%h: %s", idx, e.is_store ? "store" : "load", e.addr,
                 (errors == errs_before) ? "ok" : "error");
    endtask

    initial begin
        rst          = 1'b1;
        intp_en_i    = 1'b0;
        inst_valid_i = 1'b0;
        load_op_i    = LOAD_NONE;
        store_op_i   = STORE_NONE;
        mem_read_i   = 1'b0;
        mem_write_i  = 1'b0;
        addr_i       = '0;
        wdata_i      = '0;
        errors       = 0;
        void'($urandom(72));
        for (int i = 0; i < RAM_WORDS * 8; i++) begin
            ref_mem[i] = 8'h00;
        end
        build_table();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("access_ok_o", 64'(access_ok_o), 64'h0);
        check_value("rdata_o", rdata_o, 64'h0);
        $display("Test reset idle: %s", (errors == 0) ? "ok" : "error");
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end
        $display("Tests run %0d, errors %0d", NUM_TESTS + 1, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/lsu_pkg.sv
source/lsu_op_decode.sv
source/lsu_bus_ctrl.sv
source/lsu_load_extend.sv
source/data_ram.sv
source/mem_stage_top.sv
tb/tb_mem_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_mem_stage \
    -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "Result: FAILED" sim.log && exit 1 || exit 0
